// File: logic/qcpu_pkg.sv
package qcpu_pkg;

	localparam int WORD_W = 8;
	localparam int PC_W = 14;
	localparam int INSTR_W = 16;
	localparam int REG_IDX_W = 4;
	localparam int RAM_ADDR_W = 6;
	localparam int IO_ADDR_W = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [PC_W-1:0] pc_t;
	typedef logic [INSTR_W-1:0] instr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [IO_ADDR_W-1:0] io_addr_t;

	typedef enum logic {
		CYC_FETCH,
		CYC_EXEC
	} cycle_e;

	typedef enum logic [2:0] {
		OP_IMM,
		OP_JUMP,
		OP_BRANCH,
		OP_REGREG,
		OP_EXT,
		OP_LOAD,
		OP_STORE
	} op_class_e;

	// Instruction field positions
	localparam int F_HI_LSB = 8; // reg-reg opcode, immediate target, RAM base
	localparam int F_MID_LSB = 4; // first register, EXT opcode
	localparam int F_LO_LSB = 0; // second register, EXT register, immediate
	localparam int F_COND_LSB = 11;
	localparam int F_OFF_W = 11;

	localparam logic [3:0] RR_ADD = 4'd0;
	localparam logic [3:0] RR_ADC = 4'd1;
	localparam logic [3:0] RR_SUB = 4'd2;
	localparam logic [3:0] RR_SBB = 4'd3;
	localparam logic [3:0] RR_AND = 4'd4;
	localparam logic [3:0] RR_OR = 4'd5;
	localparam logic [3:0] RR_XOR = 4'd6;
	localparam logic [3:0] RR_NOT = 4'd7;
	localparam logic [3:0] RR_ADDI = 4'd8;
	localparam logic [3:0] RR_ADCI = 4'd9;
	localparam logic [3:0] RR_SUBI = 4'd10;
	localparam logic [3:0] RR_SBBI = 4'd11;
	localparam logic [3:0] RR_LINK = 4'd12;
	localparam logic [3:0] RR_JREG = 4'd13;
	localparam logic [3:0] RR_CMP = 4'd14;

	localparam logic [3:0] EXT_SHR = 4'd0;
	localparam logic [3:0] EXT_SHRC = 4'd1;
	localparam logic [3:0] EXT_SHL = 4'd2;
	localparam logic [3:0] EXT_SHLC = 4'd3;
	localparam logic [3:0] EXT_ROR = 4'd4;
	localparam logic [3:0] EXT_ROL = 4'd5;
	localparam logic [3:0] EXT_SETIO = 4'd6;
	localparam logic [3:0] EXT_IOW = 4'd7;
	localparam logic [3:0] EXT_IOR = 4'd8;
	localparam logic [3:0] EXT_CMPI = 4'd9;
	localparam logic [3:0] EXT_GETF = 4'd13;
	localparam logic [3:0] EXT_SETF = 4'd14;

	localparam io_addr_t IO_DDRA = 8'd0;
	localparam io_addr_t IO_PORTA = 8'd1;
	localparam io_addr_t IO_DDRB = 8'd2;
	localparam io_addr_t IO_PORTB = 8'd3;
	localparam io_addr_t IO_PINA = 8'd4;
	localparam io_addr_t IO_PINB = 8'd5;

endpackage

// File: logic/qcpu_ifs.sv
// Decoded fields of the instruction in the IR
interface dec_if;
	qcpu_pkg::op_class_e op_class;
	logic [3:0] opc; // reg-reg or EXT opcode
	qcpu_pkg::reg_idx_t ra;
	qcpu_pkg::reg_idx_t rb;
	qcpu_pkg::reg_idx_t ext_reg;
	qcpu_pkg::word_t imm;
	qcpu_pkg::ram_addr_t base;
	logic [1:0] br_cond;
	qcpu_pkg::pc_t br_off; // Already sign extended
	qcpu_pkg::pc_t jump_tgt;
	logic exec;

	modport src (
		output op_class, opc, ra, rb, ext_reg, imm, base,
		output br_cond, br_off, jump_tgt, exec
	);

	modport snk (
		input op_class, opc, ra, rb, ext_reg, imm, base,
		input br_cond, br_off, jump_tgt, exec
	);
endinterface

// Register file read ports plus the architectural state execute needs
interface rf_if;
	qcpu_pkg::reg_idx_t ra;
	qcpu_pkg::reg_idx_t rb;
	qcpu_pkg::reg_idx_t rx;
	qcpu_pkg::word_t ra_data;
	qcpu_pkg::word_t rb_data;
	qcpu_pkg::word_t rx_data;
	logic flag_c;
	logic flag_z;
	qcpu_pkg::pc_t pc;

	modport idx (output ra, rb, rx);

	modport regs (
		input ra, rb, rx,
		output ra_data, rb_data, rx_data, flag_c, flag_z, pc
	);

	modport rd (input ra, rb, rx, ra_data, rb_data, rx_data, flag_c, flag_z, pc);
endinterface

// File: logic/qcpu_decode.sv
module qcpu_decode (
	input  logic clk,
	input  logic rst_n,
	input  logic pause,
	input  qcpu_pkg::instr_t rom_data,
	output logic m1,
	dec_if.src dec,
	rf_if.idx rf
);

	qcpu_pkg::cycle_e state;
	qcpu_pkg::instr_t ir;
	qcpu_pkg::op_class_e op_class;
	logic is_jreg;
	logic is_cmpi;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= qcpu_pkg::CYC_FETCH;
			ir <= '0;
		end else if (state == qcpu_pkg::CYC_FETCH) begin
			if (!pause) begin
				state <= qcpu_pkg::CYC_EXEC;
				ir <= rom_data; // Old word replaced as the fetch completes
			end
		end else begin
			state <= qcpu_pkg::CYC_FETCH;
		end
	end

	// Class comes from the top bits, EXT is a corner of the reg-reg space
	always_comb begin
		if (ir[15:14] == 2'b00)
			op_class = qcpu_pkg::OP_JUMP;
		else if (ir[15:13] == 3'b011)
			op_class = qcpu_pkg::OP_BRANCH;
		else if (ir[15:12] == 4'b0100)
			op_class = qcpu_pkg::OP_IMM;
		else if (ir[15:8] == 8'b0101_1111)
			op_class = qcpu_pkg::OP_EXT;
		else if (ir[15:12] == 4'b0101)
			op_class = qcpu_pkg::OP_REGREG;
		else if (ir[15:14] == 2'b10)
			op_class = qcpu_pkg::OP_STORE;
		else
			op_class = qcpu_pkg::OP_LOAD;
	end

	assign is_jreg = (op_class == qcpu_pkg::OP_REGREG)
		&& (ir[qcpu_pkg::F_HI_LSB +: 4] == qcpu_pkg::RR_JREG);
	assign is_cmpi = (op_class == qcpu_pkg::OP_EXT)
		&& (ir[qcpu_pkg::F_MID_LSB +: 4] == qcpu_pkg::EXT_CMPI);

	assign dec.op_class = op_class;
	assign dec.opc = (op_class == qcpu_pkg::OP_EXT) ? ir[qcpu_pkg::F_MID_LSB +: 4]
		: ir[qcpu_pkg::F_HI_LSB +: 4];
	assign dec.ra = (op_class == qcpu_pkg::OP_IMM) ? ir[qcpu_pkg::F_HI_LSB +: 4]
		: ir[qcpu_pkg::F_MID_LSB +: 4];
	assign dec.rb = ir[qcpu_pkg::F_LO_LSB +: 4];
	assign dec.ext_reg = ir[qcpu_pkg::F_LO_LSB +: 4];
	assign dec.imm = ir[qcpu_pkg::F_LO_LSB +: 8];
	assign dec.base = ir[qcpu_pkg::F_HI_LSB +: 6];
	assign dec.br_cond = ir[qcpu_pkg::F_COND_LSB +: 2];
	assign dec.br_off = {{(qcpu_pkg::PC_W - qcpu_pkg::F_OFF_W){ir[qcpu_pkg::F_OFF_W-1]}},
		ir[qcpu_pkg::F_OFF_W-1:0]};
	assign dec.jump_tgt = ir[qcpu_pkg::PC_W-1:0];
	assign dec.exec = (state == qcpu_pkg::CYC_EXEC);

	// JREG reads R1/R2, CMPI compares against R1
	assign rf.ra = is_jreg ? qcpu_pkg::reg_idx_t'(1) : ir[qcpu_pkg::F_MID_LSB +: 4];
	assign rf.rb = is_jreg ? qcpu_pkg::reg_idx_t'(2) : ir[qcpu_pkg::F_LO_LSB +: 4];
	assign rf.rx = is_cmpi ? qcpu_pkg::reg_idx_t'(1) : ir[qcpu_pkg::F_LO_LSB +: 4];

	assign m1 = (state == qcpu_pkg::CYC_FETCH);

endmodule

// File: logic/qcpu_execute.sv
module qcpu_execute (
	dec_if.snk dec,
	rf_if.rd rf,
	output qcpu_pkg::word_t result,
	output logic new_c,
	output logic new_z,
	output logic reg_we,
	output qcpu_pkg::reg_idx_t wr_idx,
	output logic flags_we,
	output qcpu_pkg::pc_t next_pc,
	output qcpu_pkg::ram_addr_t ram_addr,
	output qcpu_pkg::word_t ram_wdata,
	input  qcpu_pkg::word_t io_rdata
);

	logic [8:0] add_b;
	logic [8:0] add_sum;
	logic [8:0] alu_res;
	logic add_cin;
	logic shift_cin;
	logic take;
	qcpu_pkg::word_t rsh;
	qcpu_pkg::word_t lsh;
	qcpu_pkg::word_t ror;
	qcpu_pkg::word_t rol;
	qcpu_pkg::pc_t pc_inc;

	// opc[3] picks the nibble immediate, opc[1] inverts for subtract
	always_comb begin
		if (dec.opc[3])
			add_b = dec.opc[1] ? {5'b0_1111, ~dec.rb} : {5'b0_0000, dec.rb};
		else
			add_b = dec.opc[1] ? {1'b0, ~rf.rb_data} : {1'b0, rf.rb_data};
	end

	assign add_cin = ((dec.opc[1:0] != 2'd0) & rf.flag_c) | (dec.opc[1:0] == 2'd2);
	assign add_sum = {1'b0, rf.ra_data} + add_b + 9'(add_cin);

	always_comb begin
		case (dec.opc)
			qcpu_pkg::RR_ADD, qcpu_pkg::RR_ADC, qcpu_pkg::RR_SUB, qcpu_pkg::RR_SBB,
			qcpu_pkg::RR_ADDI, qcpu_pkg::RR_ADCI, qcpu_pkg::RR_SUBI, qcpu_pkg::RR_SBBI:
				alu_res = add_sum;
			qcpu_pkg::RR_AND: alu_res = {rf.flag_c, rf.ra_data & rf.rb_data};
			qcpu_pkg::RR_OR: alu_res = {rf.flag_c, rf.ra_data | rf.rb_data};
			qcpu_pkg::RR_XOR: alu_res = {rf.flag_c, rf.ra_data ^ rf.rb_data};
			qcpu_pkg::RR_NOT: alu_res = {rf.flag_c, ~rf.rb_data};
			default: alu_res = {rf.flag_c, rf.ra_data};
		endcase
	end

	assign shift_cin = rf.flag_c & dec.opc[0]; // Odd shift opcodes pull in C
	assign rsh = {shift_cin, rf.rx_data[7:1]};
	assign lsh = {rf.rx_data[6:0], shift_cin};
	assign ror = {rf.rx_data[0], rf.rx_data[7:1]};
	assign rol = {rf.rx_data[6:0], rf.rx_data[7]};

	always_comb begin
		case (dec.br_cond)
			2'd0: take = !rf.flag_c;
			2'd1: take = rf.flag_c;
			2'd2: take = !rf.flag_z;
			default: take = rf.flag_z;
		endcase
	end

	assign pc_inc = rf.pc + qcpu_pkg::pc_t'(1);
	assign ram_addr = dec.base + rf.rb_data[qcpu_pkg::RAM_ADDR_W-1:0];
	assign ram_wdata = rf.ra_data;

	always_comb begin
		result = '0;
		new_c = rf.flag_c;
		new_z = rf.flag_z;
		reg_we = 1'b0;
		flags_we = 1'b0;
		wr_idx = dec.ra;
		next_pc = pc_inc;
		case (dec.op_class)
			qcpu_pkg::OP_IMM: begin
				result = dec.imm;
				reg_we = 1'b1;
			end
			qcpu_pkg::OP_JUMP: next_pc = dec.jump_tgt;
			qcpu_pkg::OP_BRANCH: if (take) next_pc = rf.pc + dec.br_off;
			qcpu_pkg::OP_REGREG: begin
				case (dec.opc)
					qcpu_pkg::RR_LINK: ; // R1/R2 written in result
					qcpu_pkg::RR_JREG: next_pc = {rf.rb_data[5:0], rf.ra_data};
					qcpu_pkg::RR_CMP: begin
						new_c = rf.ra_data >= rf.rb_data;
						new_z = rf.ra_data == rf.rb_data;
						flags_we = 1'b1;
					end
					default: begin
						result = alu_res[7:0];
						new_c = alu_res[8];
						new_z = alu_res[7:0] == '0;
						reg_we = 1'b1;
						flags_we = 1'b1;
					end
				endcase
			end
			qcpu_pkg::OP_EXT: begin
				wr_idx = dec.ext_reg;
				case (dec.opc)
					qcpu_pkg::EXT_SHR, qcpu_pkg::EXT_SHRC: begin
						result = rsh;
						new_c = rf.rx_data[0];
						new_z = rsh == '0;
						reg_we = 1'b1;
						flags_we = 1'b1;
					end
					qcpu_pkg::EXT_SHL, qcpu_pkg::EXT_SHLC: begin
						result = lsh;
						new_c = rf.rx_data[7];
						new_z = lsh == '0;
						reg_we = 1'b1;
						flags_we = 1'b1;
					end
					qcpu_pkg::EXT_ROR: begin
						result = ror;
						new_z = ror == '0;
						reg_we = 1'b1;
						flags_we = 1'b1;
					end
					qcpu_pkg::EXT_ROL: begin
						result = rol;
						new_z = rol == '0;
						reg_we = 1'b1;
						flags_we = 1'b1;
					end
					qcpu_pkg::EXT_SETIO, qcpu_pkg::EXT_IOW: result = rf.rx_data;
					qcpu_pkg::EXT_IOR: begin
						result = io_rdata;
						reg_we = 1'b1;
					end
					qcpu_pkg::EXT_CMPI: begin
						new_c = rf.rx_data >= {4'h0, dec.ext_reg};
						new_z = rf.rx_data == {4'h0, dec.ext_reg};
						flags_we = 1'b1;
					end
					qcpu_pkg::EXT_GETF: begin
						result = {6'b0, rf.flag_z, rf.flag_c};
						reg_we = 1'b1;
					end
					qcpu_pkg::EXT_SETF: begin
						new_c = rf.rx_data[0];
						new_z = rf.rx_data[1];
						flags_we = 1'b1;
					end
					default: ;
				endcase
			end
			qcpu_pkg::OP_LOAD: reg_we = 1'b1; // Data picked up from RAM in result
			default: ;
		endcase
	end

endmodule

// File: logic/qcpu_result.sv
module qcpu_result #(
	parameter qcpu_pkg::pc_t RESET_PC = '0
) (
	input  logic clk,
	input  logic rst_n,
	dec_if.snk dec,
	rf_if.regs rf,
	input  qcpu_pkg::word_t result,
	input  logic new_c,
	input  logic new_z,
	input  logic reg_we,
	input  qcpu_pkg::reg_idx_t wr_idx,
	input  logic flags_we,
	input  qcpu_pkg::pc_t next_pc,
	input  qcpu_pkg::word_t ram_rdata,
	output logic ram_we,
	output qcpu_pkg::word_t io_rdata,
	input  qcpu_pkg::word_t pina,
	input  qcpu_pkg::word_t pinb,
	output qcpu_pkg::word_t porta,
	output qcpu_pkg::word_t portb,
	output qcpu_pkg::word_t porta_ddr,
	output qcpu_pkg::word_t portb_ddr
);

	qcpu_pkg::word_t regs [16];
	qcpu_pkg::pc_t pc;
	qcpu_pkg::pc_t pc_link;
	qcpu_pkg::io_addr_t io_addr;
	qcpu_pkg::word_t wdata;
	logic flag_c;
	logic flag_z;
	logic commit;
	logic link;
	logic set_io;
	logic io_wr;

	assign commit = dec.exec;
	assign link = (dec.op_class == qcpu_pkg::OP_REGREG) && (dec.opc == qcpu_pkg::RR_LINK);
	assign set_io = ((dec.op_class == qcpu_pkg::OP_IMM) && (dec.ra == '0))
		|| ((dec.op_class == qcpu_pkg::OP_EXT) && (dec.opc == qcpu_pkg::EXT_SETIO));
	assign io_wr = (dec.op_class == qcpu_pkg::OP_EXT) && (dec.opc == qcpu_pkg::EXT_IOW);
	assign pc_link = pc + qcpu_pkg::pc_t'(2);
	assign wdata = (dec.op_class == qcpu_pkg::OP_LOAD) ? ram_rdata : result;

	always_ff @(posedge clk) begin
		if (commit) begin
			if (link) begin
				regs[1] <= pc_link[7:0];
				regs[2] <= {2'b00, pc_link[qcpu_pkg::PC_W-1:8]};
			end else if (reg_we && wr_idx != '0) begin
				regs[wr_idx] <= wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			flag_c <= 1'b0;
			flag_z <= 1'b0;
			io_addr <= '0;
			ram_we <= 1'b0;
			porta <= '0;
			portb <= '0;
			porta_ddr <= '0;
			portb_ddr <= '0;
		end else begin
			ram_we <= commit && (dec.op_class == qcpu_pkg::OP_STORE); // One cycle strobe
			if (commit) begin
				pc <= next_pc;
				if (flags_we) begin
					flag_c <= new_c;
					flag_z <= new_z;
				end
				if (set_io)
					io_addr <= result;
				if (io_wr) begin
					case (io_addr)
						qcpu_pkg::IO_DDRA: porta_ddr <= result;
						qcpu_pkg::IO_PORTA: porta <= result;
						qcpu_pkg::IO_DDRB: portb_ddr <= result;
						qcpu_pkg::IO_PORTB: portb <= result;
						default: ; // Pins and unmapped addresses
					endcase
				end
			end
		end
	end

	always_comb begin
		case (io_addr)
			qcpu_pkg::IO_DDRA: io_rdata = porta_ddr;
			qcpu_pkg::IO_PORTA: io_rdata = porta;
			qcpu_pkg::IO_DDRB: io_rdata = portb_ddr;
			qcpu_pkg::IO_PORTB: io_rdata = portb;
			qcpu_pkg::IO_PINA: io_rdata = pina;
			qcpu_pkg::IO_PINB: io_rdata = pinb;
			default: io_rdata = '0;
		endcase
	end

	// R0 reads as zero
	assign rf.ra_data = (rf.ra == '0) ? '0 : regs[rf.ra];
	assign rf.rb_data = (rf.rb == '0) ? '0 : regs[rf.rb];
	assign rf.rx_data = (rf.rx == '0) ? '0 : regs[rf.rx];
	assign rf.flag_c = flag_c;
	assign rf.flag_z = flag_z;
	assign rf.pc = pc;

endmodule

// File: logic/qcpu_top.sv
module qcpu_top #(
	parameter qcpu_pkg::pc_t RESET_PC = '0
) (
	input  logic clk,
	input  logic rst_n,
	input  logic pause,
	output logic m1,
	output qcpu_pkg::pc_t rom_addr,
	input  qcpu_pkg::instr_t rom_data,
	output qcpu_pkg::ram_addr_t ram_addr,
	output qcpu_pkg::word_t ram_wdata,
	input  qcpu_pkg::word_t ram_rdata,
	output logic ram_we,
	output qcpu_pkg::word_t porta,
	output qcpu_pkg::word_t portb,
	output qcpu_pkg::word_t porta_ddr,
	output qcpu_pkg::word_t portb_ddr,
	input  qcpu_pkg::word_t pina,
	input  qcpu_pkg::word_t pinb
);

	dec_if dec_bus ();
	rf_if rf_bus ();

	qcpu_pkg::word_t result;
	qcpu_pkg::word_t io_rdata;
	qcpu_pkg::reg_idx_t wr_idx;
	qcpu_pkg::pc_t next_pc;
	logic new_c;
	logic new_z;
	logic reg_we;
	logic flags_we;

	assign rom_addr = rf_bus.pc; // Fetch straight from the PC

	qcpu_decode u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.pause    (pause),
		.rom_data (rom_data),
		.m1       (m1),
		.dec      (dec_bus.src),
		.rf       (rf_bus.idx)
	);

	qcpu_execute u_execute (
		.dec       (dec_bus.snk),
		.rf        (rf_bus.rd),
		.result    (result),
		.new_c     (new_c),
		.new_z     (new_z),
		.reg_we    (reg_we),
		.wr_idx    (wr_idx),
		.flags_we  (flags_we),
		.next_pc   (next_pc),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.io_rdata  (io_rdata)
	);

	qcpu_result #(
		.RESET_PC (RESET_PC)
	) u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.dec       (dec_bus.snk),
		.rf        (rf_bus.regs),
		.result    (result),
		.new_c     (new_c),
		.new_z     (new_z),
		.reg_we    (reg_we),
		.wr_idx    (wr_idx),
		.flags_we  (flags_we),
		.next_pc   (next_pc),
		.ram_rdata (ram_rdata),
		.ram_we    (ram_we),
		.io_rdata  (io_rdata),
		.pina      (pina),
		.pinb      (pinb),
		.porta     (porta),
		.portb     (portb),
		.porta_ddr (porta_ddr),
		.portb_ddr (portb_ddr)
	);

endmodule

// File: sim/qcpu_asserts.sv
module qcpu_asserts (
	input logic clk,
	input logic rst_n,
	input logic pause,
	input logic m1,
	input logic ram_we,
	input qcpu_pkg::pc_t rom_addr
);
	timeunit 1ns;
	timeprecision 1ps;

	// Execute is always followed by a fetch
	exec_then_fetch: assert property (@(posedge clk) disable iff (!rst_n) !m1 |=> m1)
		else $error("execute cycle not followed by fetch");

	fetch_then_exec: assert property (@(posedge clk) disable iff (!rst_n)
		(m1 && !pause) |=> !m1)
		else $error("fetch without pause not followed by execute");

	we_single: assert property (@(posedge clk) disable iff (!rst_n) ram_we |=> !ram_we)
		else $error("ram_we high for more than one cycle");

	pause_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(m1 && pause) |=> (m1 && $stable(rom_addr)))
		else $error("fetch left or rom_addr moved while paused");

endmodule

bind qcpu_top qcpu_asserts u_asserts (
	.clk      (clk),
	.rst_n    (rst_n),
	.pause    (pause),
	.m1       (m1),
	.ram_we   (ram_we),
	.rom_addr (rom_addr)
);

// File: sim/qcpu_tb.sv
module qcpu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk = 1'b0;
	logic rst_n;
	logic pause;
	logic m1;
	logic ram_we;
	qcpu_pkg::pc_t rom_addr;
	qcpu_pkg::instr_t rom_data;
	qcpu_pkg::ram_addr_t ram_addr;
	qcpu_pkg::word_t ram_wdata;
	qcpu_pkg::word_t ram_rdata;
	qcpu_pkg::word_t porta;
	qcpu_pkg::word_t portb;
	qcpu_pkg::word_t porta_ddr;
	qcpu_pkg::word_t portb_ddr;
	qcpu_pkg::word_t pina;
	qcpu_pkg::word_t pinb;

	qcpu_pkg::instr_t rom [1 << qcpu_pkg::PC_W];
	qcpu_pkg::word_t ram [1 << qcpu_pkg::RAM_ADDR_W];
	qcpu_pkg::pc_t wp; // Next free ROM slot
	qcpu_pkg::word_t seen [$]; // PORTA values in order of appearance
	qcpu_pkg::word_t last_a;
	logic [31:0] rng = 32'd42;

	always #20 clk = ~clk;

	qcpu_top #(.RESET_PC('0)) UUT (.*);

	assign rom_data = rom[rom_addr];
	assign ram_rdata = ram[ram_addr];

	always @(posedge clk) begin
		if (ram_we)
			ram[ram_addr] <= ram_wdata;
	end

	always @(negedge clk) begin
		if (!rst_n)
			last_a = '0;
		else if (porta != last_a) begin
			seen.push_back(porta);
			last_a = porta;
		end
	end

	function automatic logic [31:0] xorshift();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic qcpu_pkg::instr_t enc_imm(input logic [3:0] r, input qcpu_pkg::word_t v);
		return {4'b0100, r, v};
	endfunction

	function automatic qcpu_pkg::instr_t enc_ext(input logic [3:0] op, input logic [3:0] r);
		return {8'h5f, op, r};
	endfunction

	function automatic qcpu_pkg::instr_t enc_rr(input logic [3:0] op, a, b);
		return {4'b0101, op, a, b};
	endfunction

	function automatic qcpu_pkg::instr_t enc_br(input logic [1:0] cond, input logic [10:0] off);
		return {3'b011, cond, off};
	endfunction

	function automatic logic branch_taken(input logic [1:0] cond, input logic c, z);
		case (cond)
			2'd0: return !c;
			2'd1: return c;
			2'd2: return !z;
			default: return z;
		endcase
	endfunction

	// Returns {c, z, result}
	function automatic logic [9:0] alu_model(input logic [3:0] op,
		input qcpu_pkg::word_t a, b, input logic cin);
		logic [8:0] s;
		qcpu_pkg::word_t bb;
		qcpu_pkg::word_t r;
		logic ci;
		logic c;
		bb = op[3] ? {4'h0, b[3:0]} : b; // Immediate forms use the nibble
		ci = (op[1:0] == 2'd0) ? 1'b0 : (op[1:0] == 2'd2) ? 1'b1 : cin;
		c = cin;
		case (op)
			4'd4: r = a & b;
			4'd5: r = a | b;
			4'd6: r = a ^ b;
			4'd7: r = ~b;
			default: begin
				if (op[1])
					s = {1'b0, a} + {1'b0, ~bb} + 9'(ci);
				else
					s = {1'b0, a} + {1'b0, bb} + 9'(ci);
				r = s[7:0];
				c = s[8];
			end
		endcase
		return {c, r == 8'h00, r};
	endfunction

	function automatic logic [9:0] shift_model(input logic [3:0] op,
		input qcpu_pkg::word_t a, input logic cin);
		qcpu_pkg::word_t r;
		logic c;
		c = cin;
		case (op)
			4'd0, 4'd1: begin
				r = {cin & op[0], a[7:1]};
				c = a[0];
			end
			4'd2, 4'd3: begin
				r = {a[6:0], cin & op[0]};
				c = a[7];
			end
			4'd4: r = {a[0], a[7:1]};
			default: r = {a[6:0], a[7]};
		endcase
		return {c, r == 8'h00, r};
	endfunction

	task automatic die(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input qcpu_pkg::word_t got, exp);
		if (got !== exp)
			die($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_pc(input string name, input qcpu_pkg::pc_t got, exp);
		if (got !== exp)
			die($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_addr(input string name, input qcpu_pkg::ram_addr_t got, exp);
		if (got !== exp)
			die($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp)
			die($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	// Unused slots hold a jump to themselves
	task automatic clear_rom();
		for (int i = 0; i < (1 << qcpu_pkg::PC_W); i++)
			rom[i] = {2'b00, qcpu_pkg::pc_t'(i)};
		wp = '0;
	endtask

	task automatic put(input qcpu_pkg::instr_t instr);
		rom[wp] = instr;
		wp = wp + 1'b1;
	endtask

	task automatic put_marker(input qcpu_pkg::word_t m);
		put(enc_imm(4'd8, m));
		put(enc_ext(qcpu_pkg::EXT_IOW, 4'd8));
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		pause = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic hold_pause(input int cycles);
		qcpu_pkg::pc_t held;
		pause = 1'b1;
		@(negedge clk);
		held = rom_addr;
		repeat (cycles) begin
			@(negedge clk);
			check_pc("rom_addr", rom_addr, held);
			check_bit("m1", m1, 1'b1);
		end
		pause = 1'b0;
	endtask

	// Runs until the PC sits on the first free slot
	task automatic wait_end(input int pause_at);
		int cyc;
		for (cyc = 0; cyc < 400 && !(m1 && rom_addr == wp); cyc++) begin
			if (pause_at != 0 && cyc == pause_at)
				hold_pause(5);
			@(negedge clk);
		end
		if (!(m1 && rom_addr == wp))
			die("timeout: program did not reach its final address");
	endtask

	// Loads operands and flags, runs one instruction, reports result and flags
	task automatic run_case(input qcpu_pkg::instr_t instr, input qcpu_pkg::word_t a, b,
		input logic cin, zin, input logic [9:0] exp, input int pause_at);
		clear_rom();
		put(enc_imm(4'd1, a));
		put(enc_imm(4'd3, a));
		put(enc_imm(4'd4, b));
		put(enc_imm(4'd5, {6'b0, zin, cin}));
		put(enc_ext(qcpu_pkg::EXT_SETF, 4'd5));
		put(instr);
		put(enc_imm(4'd0, qcpu_pkg::IO_PORTA));
		put(enc_ext(qcpu_pkg::EXT_IOW, 4'd3));
		put(enc_ext(qcpu_pkg::EXT_GETF, 4'd6));
		put(enc_imm(4'd0, qcpu_pkg::IO_PORTB));
		put(enc_ext(qcpu_pkg::EXT_IOW, 4'd6));
		apply_reset();
		wait_end(pause_at);
		check_word("porta", porta, exp[7:0]);
		check_word("portb", portb, {6'b0, exp[8], exp[9]});
	endtask

	task automatic test_reset();
		apply_reset();
		check_bit("m1", m1, 1'b1);
		check_pc("rom_addr", rom_addr, '0);
		check_bit("ram_we", ram_we, 1'b0);
		check_word("porta", porta, '0);
		check_word("portb", portb, '0);
		check_word("porta_ddr", porta_ddr, '0);
		check_word("portb_ddr", portb_ddr, '0);
	endtask

	task automatic test_alu();
		qcpu_pkg::word_t a;
		qcpu_pkg::word_t b;
		logic [1:0] f;
		for (int op = 0; op < 12; op++) begin
			a = qcpu_pkg::word_t'(xorshift());
			b = qcpu_pkg::word_t'(xorshift());
			f = 2'(xorshift());
			run_case(enc_rr(4'(op), 4'd3, (op >= 8) ? b[3:0] : 4'd4), a, b, f[0], f[1],
				alu_model(4'(op), a, b, f[0]), 0);
		end
	endtask

	task automatic test_control();
		qcpu_pkg::word_t exp [$];
		qcpu_pkg::word_t a;
		qcpu_pkg::word_t b;
		qcpu_pkg::word_t m;
		qcpu_pkg::pc_t p;
		clear_rom();
		m = 8'h10;
		put(enc_imm(4'd0, qcpu_pkg::IO_PORTA));
		// Operands below, above and equal give each branch both ways
		for (int k = 0; k < 3; k++) begin
			a = qcpu_pkg::word_t'(xorshift());
			b = a ^ (qcpu_pkg::word_t'(xorshift()) | 8'h01);
			if (k == 2)
				b = a;
			else if ((k == 0) == (a > b))
				{a, b} = {b, a};
			put(enc_imm(4'd3, a));
			put(enc_imm(4'd4, b));
			put(enc_rr(qcpu_pkg::RR_CMP, 4'd3, 4'd4));
			for (int cond = 0; cond < 4; cond++) begin
				put(enc_br(2'(cond), 11'd3)); // Skips the next marker when taken
				put_marker(m);
				if (!branch_taken(2'(cond), a >= b, a == b))
					exp.push_back(m);
				put_marker(m + 8'd1);
				exp.push_back(m + 8'd1);
				m = m + 8'd2;
			end
		end
		put({2'b00, wp + 14'd3});
		put_marker(8'h70);
		put_marker(8'h71);
		exp.push_back(8'h71);
		p = wp;
		put(enc_rr(qcpu_pkg::RR_LINK, 4'd0, 4'd0)); // R2:R1 = p+2
		put({2'b00, p + 14'd5});
		put_marker(8'h81);
		put({2'b00, p + 14'd8});
		put_marker(8'h80);
		put(enc_rr(qcpu_pkg::RR_JREG, 4'd0, 4'd0));
		exp.push_back(8'h80);
		exp.push_back(8'h81);
		seen.delete();
		apply_reset();
		wait_end(0);
		if (seen.size() != exp.size())
			die($sformatf("wrong number of PORTA markers: %0d seen, %0d expected",
				seen.size(), exp.size()));
		foreach (exp[i])
			check_word("porta marker", seen[i], exp[i]);
	endtask

	task automatic test_memory();
		qcpu_pkg::word_t d;
		qcpu_pkg::ram_addr_t idx;
		qcpu_pkg::ram_addr_t base;
		qcpu_pkg::ram_addr_t st_addr;
		int i;
		for (int k = 0; k < (1 << qcpu_pkg::RAM_ADDR_W); k++)
			ram[k] = 8'(k * 37) ^ 8'h5a;
		d = qcpu_pkg::word_t'(xorshift());
		idx = qcpu_pkg::ram_addr_t'(xorshift());
		base = qcpu_pkg::ram_addr_t'(xorshift());
		st_addr = base + idx;
		clear_rom();
		put(enc_imm(4'd3, d));
		put(enc_imm(4'd4, {2'b00, idx}));
		put({2'b10, base, 4'd3, 4'd4});
		put({2'b11, base + 6'd1, 4'd5, 4'd4});
		put(enc_imm(4'd0, qcpu_pkg::IO_PORTB));
		put(enc_ext(qcpu_pkg::EXT_IOW, 4'd5));
		apply_reset();
		for (i = 0; i < 50 && !ram_we; i++)
			@(negedge clk);
		if (!ram_we)
			die("timeout: store never raised ram_we");
		check_addr("ram_addr", ram_addr, st_addr);
		check_word("ram_wdata", ram_wdata, d);
		@(negedge clk);
		check_bit("ram_we", ram_we, 1'b0);
		wait_end(0);
		check_word("ram word", ram[st_addr], d);
		check_word("portb", portb, 8'(qcpu_pkg::ram_addr_t'(st_addr + 6'd1) * 37) ^ 8'h5a);
	endtask

	task automatic test_shift_io();
		qcpu_pkg::word_t a;
		logic [1:0] f;
		for (int op = 0; op < 6; op++) begin
			a = qcpu_pkg::word_t'(xorshift());
			f = 2'(xorshift());
			run_case(enc_ext(4'(op), 4'd3), a, 8'h00, f[0], f[1],
				shift_model(4'(op), a, f[0]), 0);
		end
		a = qcpu_pkg::word_t'(xorshift());
		run_case(enc_ext(qcpu_pkg::EXT_CMPI, 4'd9), a, 8'h00, 1'b0, 1'b0,
			{a >= 8'd9, a == 8'd9, a}, 0);
		run_case(enc_ext(qcpu_pkg::EXT_CMPI, 4'd6), 8'd6, 8'h00, 1'b0, 1'b0,
			{1'b1, 1'b1, 8'd6}, 0);
		@(negedge clk);
		pina = qcpu_pkg::word_t'(xorshift());
		pinb = qcpu_pkg::word_t'(xorshift());
		clear_rom();
		put(enc_imm(4'd0, qcpu_pkg::IO_PINA));
		put(enc_ext(qcpu_pkg::EXT_IOR, 4'd7));
		put(enc_imm(4'd0, qcpu_pkg::IO_PORTB));
		put(enc_ext(qcpu_pkg::EXT_IOW, 4'd7));
		put(enc_imm(4'd0, qcpu_pkg::IO_PINB));
		put(enc_ext(qcpu_pkg::EXT_IOR, 4'd9));
		put(enc_imm(4'd0, qcpu_pkg::IO_PORTA));
		put(enc_ext(qcpu_pkg::EXT_IOW, 4'd9));
		put(enc_imm(4'd0, qcpu_pkg::IO_DDRA));
		put(enc_ext(qcpu_pkg::EXT_IOW, 4'd9));
		put(enc_imm(4'd0, qcpu_pkg::IO_DDRB));
		put(enc_ext(qcpu_pkg::EXT_IOW, 4'd7));
		apply_reset();
		wait_end(0);
		check_word("portb", portb, pina);
		check_word("porta", porta, pinb);
		check_word("porta_ddr", porta_ddr, pinb);
		check_word("portb_ddr", portb_ddr, pina);
	endtask

	task automatic test_pause();
		qcpu_pkg::word_t a;
		qcpu_pkg::word_t b;
		a = qcpu_pkg::word_t'(xorshift());
		b = qcpu_pkg::word_t'(xorshift());
		run_case(enc_rr(qcpu_pkg::RR_ADD, 4'd3, 4'd4), a, b, 1'b0, 1'b0,
			alu_model(qcpu_pkg::RR_ADD, a, b, 1'b0), 0);
		// Two start points so the pause lands in both cycle phases
		for (int at = 3; at < 5; at++) begin
			run_case(enc_rr(qcpu_pkg::RR_ADD, 4'd3, 4'd4), a, b, 1'b0, 1'b0,
				alu_model(qcpu_pkg::RR_ADD, a, b, 1'b0), at);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		pause = 1'b0;
		pina = '0;
		pinb = '0;
		clear_rom();
		test_reset();
		test_alu();
		test_control();
		test_memory();
		test_shift_io();
		test_pause();
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: sources.f
logic/qcpu_pkg.sv
logic/qcpu_ifs.sv
logic/qcpu_decode.sv
logic/qcpu_execute.sv
logic/qcpu_result.sv
logic/qcpu_top.sv
sim/qcpu_asserts.sv
sim/qcpu_tb.sv

// File: Makefile
# Verilator build for the qcpu core and its testbench

VERILATOR ?= verilator
FILELIST ?= sources.f
TB_TOP ?= qcpu_tb
RTL_TOP ?= qcpu_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
PASS_TEXT ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
